// File: Bender.yml
package:
  name: lce_cmd

sources:
  - design/lce_cmd_pkg.sv
  - design/cache_mem_if.sv
  - design/lce_readback_buf.sv
  - design/lce_cmd_ctrl.sv
  - design/lce_cmd_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_lce_cmd.sv

// File: design/cache_mem_if.sv
// One cache memory port, valid->yumi.
// The controller offers a packet, the memory accepts it with yumi, and for a read
// the result appears on rdata in the cycle after acceptance.

`timescale 1ns/1ps

interface cache_mem_if #(
  parameter type pkt_t   = logic,
  parameter type rdata_t = logic
);

  pkt_t   pkt;
  logic   v;
  logic   yumi;
  rdata_t rdata;

  modport ctrl (
    output pkt, v,
    input  yumi
  );

  // readback buffers only observe the port
  modport rdbuf (
    input v, yumi, pkt, rdata
  );

  modport mem (
    input  pkt, v,
    output yumi, rdata
  );

endinterface

// File: design/lce_cmd_ctrl.sv
// LCE command controller.
// Clears tag and stat memories after reset, then handles one CCE command at a time,
// forming the tag, stat and data packets and the response for each.
// The command stays on lce_cmd_i until lce_cmd_yumi_o dequeues it.

`timescale 1ns/1ps

module lce_cmd_ctrl
  import lce_cmd_pkg::*;
#(
  parameter int unsigned sets_p    = 16,
  parameter int unsigned num_cce_p = 2
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [id_width-1:0] lce_id_i,

  cache_mem_if.ctrl           tag_mem,
  cache_mem_if.ctrl           stat_mem,
  cache_mem_if.ctrl           data_mem,

  input  stat_info_s          stat_buf_i,
  input  logic                stat_buf_v_i,
  input  block_t              data_buf_i,
  input  logic                data_buf_v_i,

  input  lce_cmd_s            lce_cmd_i,
  input  logic                lce_cmd_v_i,
  output logic                lce_cmd_yumi_o,

  output lce_resp_s           lce_resp_o,
  output logic                lce_resp_v_o,
  input  logic                lce_resp_ready_i,

  output logic                ready_o,
  output logic                sync_done_o,
  output logic                cache_req_complete_o
);

  // counter covers both the set sweep and the sync count
  localparam int unsigned cnt_max_lp   = (sets_p > num_cce_p) ? sets_p : num_cce_p;
  localparam int unsigned cnt_width_lp = $clog2(cnt_max_lp + 1);

  typedef enum logic [2:0] {
    e_reset,
    e_clear,
    e_ready,
    e_coh_ack,
    e_wb,
    e_wb_dirty_rd,
    e_wb_dirty_send
  } state_e;

  state_e state_r, state_n;

  logic [cnt_width_lp-1:0] cnt_r;
  logic                    cnt_inc;
  logic                    cnt_clear;
  logic                    sync_done_set;

  logic [index_width-1:0]  cmd_index;
  logic [ptag_width-1:0]   cmd_tag;
  logic [way_width-1:0]    cmd_way;
  logic                    way_dirty;
  logic                    both_yumi;

  tag_pkt_s                tag_pkt;
  stat_pkt_s               stat_pkt;
  data_pkt_s               data_pkt;
  lce_resp_s               resp;

  assign cmd_index = lce_cmd_i.header.addr[block_offset_width +: index_width];
  assign cmd_tag   = lce_cmd_i.header.addr[paddr_width-1 -: ptag_width];
  assign cmd_way   = lce_cmd_i.header.way_id;
  assign way_dirty = stat_buf_i.dirty[cmd_way];

  assign tag_mem.pkt  = tag_pkt;
  assign stat_mem.pkt = stat_pkt;
  assign data_mem.pkt = data_pkt;
  assign lce_resp_o   = resp;

  assign ready_o = (state_r != e_reset) && (state_r != e_clear);

  always_comb begin
    state_n              = state_r;
    tag_pkt              = '0;
    stat_pkt             = '0;
    data_pkt             = '0;
    tag_mem.v            = 1'b0;
    stat_mem.v           = 1'b0;
    data_mem.v           = 1'b0;
    lce_cmd_yumi_o       = 1'b0;
    lce_resp_v_o         = 1'b0;
    cache_req_complete_o = 1'b0;
    cnt_inc              = 1'b0;
    cnt_clear            = 1'b0;
    sync_done_set        = 1'b0;
    both_yumi            = 1'b0;

    // every response goes back to the commanding CCE
    resp                 = '0;
    resp.header.src_id   = lce_id_i;
    resp.header.dst_id   = lce_cmd_i.header.src_id;
    resp.header.addr     = lce_cmd_i.header.addr;

    case (state_r)
      e_reset: begin
        state_n = e_clear;
      end

      // sweep every set to invalid, one set per cycle
      e_clear: begin
        tag_pkt.opcode  = e_tag_op_set_clear;
        tag_pkt.index   = index_width'(cnt_r);
        tag_pkt.state   = e_coh_i;
        tag_mem.v       = 1'b1;
        stat_pkt.opcode = e_stat_op_set_clear;
        stat_pkt.index  = index_width'(cnt_r);
        stat_mem.v      = 1'b1;
        both_yumi       = tag_mem.yumi & stat_mem.yumi;
        if (both_yumi && (cnt_r == cnt_width_lp'(sets_p - 1))) begin
          cnt_clear = 1'b1;
          state_n   = e_ready;
        end else begin
          cnt_inc = both_yumi;
        end
      end

      e_ready: begin
        if (lce_cmd_v_i) begin
          case (lce_cmd_i.header.msg_type)
            e_lce_cmd_sync: begin
              resp.header.msg_type = e_lce_resp_sync_ack;
              lce_resp_v_o         = lce_resp_ready_i;
              lce_cmd_yumi_o       = lce_resp_v_o;
              // last expected sync finishes synchronization
              if (lce_resp_v_o && (cnt_r == cnt_width_lp'(num_cce_p - 1))) begin
                cnt_clear     = 1'b1;
                sync_done_set = 1'b1;
              end else begin
                cnt_inc = lce_resp_v_o;
              end
            end

            e_lce_cmd_inv: begin
              tag_pkt.opcode       = e_tag_op_invalidate;
              tag_pkt.index        = cmd_index;
              tag_pkt.way_id       = cmd_way;
              tag_pkt.state        = e_coh_i;
              tag_mem.v            = 1'b1;
              resp.header.msg_type = e_lce_resp_inv_ack;
              lce_resp_v_o         = tag_mem.yumi & lce_resp_ready_i;
              lce_cmd_yumi_o       = lce_resp_v_o;
            end

            e_lce_cmd_st: begin
              tag_pkt.opcode = e_tag_op_set_state;
              tag_pkt.index  = cmd_index;
              tag_pkt.way_id = cmd_way;
              tag_pkt.state  = lce_cmd_i.header.state;
              tag_pkt.tag    = cmd_tag;
              tag_mem.v      = 1'b1;
              lce_cmd_yumi_o = tag_mem.yumi;
            end

            // fill completes a miss, ack follows once both writes land
            e_lce_cmd_data: begin
              data_pkt.opcode = e_data_op_write;
              data_pkt.index  = cmd_index;
              data_pkt.way_id = cmd_way;
              data_pkt.data   = lce_cmd_i.data;
              data_mem.v      = 1'b1;
              tag_pkt.opcode  = e_tag_op_set_tag;
              tag_pkt.index   = cmd_index;
              tag_pkt.way_id  = cmd_way;
              tag_pkt.state   = lce_cmd_i.header.state;
              tag_pkt.tag     = cmd_tag;
              tag_mem.v       = 1'b1;
              if (tag_mem.yumi && data_mem.yumi) begin
                state_n = e_coh_ack;
              end
            end

            e_lce_cmd_wb: begin
              stat_pkt.opcode = e_stat_op_read;
              stat_pkt.index  = cmd_index;
              stat_pkt.way_id = cmd_way;
              stat_mem.v      = 1'b1;
              if (stat_mem.yumi) begin
                state_n = e_wb;
              end
            end

            // reserved encodings are dropped
            default: begin
              lce_cmd_yumi_o = 1'b1;
            end
          endcase
        end
      end

      e_coh_ack: begin
        resp.header.msg_type = e_lce_resp_coh_ack;
        lce_resp_v_o         = lce_cmd_v_i & lce_resp_ready_i;
        lce_cmd_yumi_o       = lce_resp_v_o;
        cache_req_complete_o = lce_cmd_yumi_o;
        if (lce_cmd_yumi_o) begin
          state_n = e_ready;
        end
      end

      // wait for the dirty bits, a clean way answers with null_wb
      e_wb: begin
        resp.header.msg_type = e_lce_resp_null_wb;
        lce_resp_v_o         = lce_resp_ready_i & stat_buf_v_i & ~way_dirty;
        lce_cmd_yumi_o       = lce_resp_v_o;
        if (stat_buf_v_i && way_dirty) begin
          state_n = e_wb_dirty_rd;
        end else if (lce_cmd_yumi_o) begin
          state_n = e_ready;
        end
      end

      e_wb_dirty_rd: begin
        data_pkt.opcode = e_data_op_read;
        data_pkt.index  = cmd_index;
        data_pkt.way_id = cmd_way;
        data_mem.v      = 1'b1;
        stat_pkt.opcode = e_stat_op_clear_dirty;
        stat_pkt.index  = cmd_index;
        stat_pkt.way_id = cmd_way;
        stat_mem.v      = 1'b1;
        if (data_mem.yumi && stat_mem.yumi) begin
          state_n = e_wb_dirty_send;
        end
      end

      e_wb_dirty_send: begin
        resp.header.msg_type = e_lce_resp_wb;
        resp.header.size     = block_size_code;
        resp.data            = data_buf_i;
        lce_resp_v_o         = lce_resp_ready_i & data_buf_v_i;
        lce_cmd_yumi_o       = lce_resp_v_o;
        if (lce_cmd_yumi_o) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= e_reset;
      cnt_r       <= '0;
      sync_done_o <= 1'b0;
    end else begin
      state_r <= state_n;
      if (cnt_clear) begin
        cnt_r <= '0;
      end else if (cnt_inc) begin
        cnt_r <= cnt_r + cnt_width_lp'(1);
      end
      // stays set until the next reset
      if (sync_done_set) begin
        sync_done_o <= 1'b1;
      end
    end
  end

endmodule

// File: design/lce_cmd_pkg.sv
// Shared definitions for the LCE command handler.
// Holds widths, opcode and message encodings, and the packet and message structs
// used between the CCE, the handler and the cache memories.
// Import it with a wildcard import in the module header.

package lce_cmd_pkg;

  localparam int unsigned paddr_width        = 32;
  localparam int unsigned block_width        = 128;
  localparam int unsigned assoc              = 4;
  localparam int unsigned max_sets           = 16;
  localparam int unsigned index_width        = 4;
  localparam int unsigned way_width          = 2;
  localparam int unsigned block_offset_width = 4;
  localparam int unsigned ptag_width         = paddr_width - index_width - block_offset_width;
  localparam int unsigned id_width           = 4;
  localparam int unsigned size_width         = 3;

  // log2 of the block size in bytes, so 16 bytes per block
  localparam logic [size_width-1:0] block_size_code = 3'd4;

  typedef logic [block_width-1:0] block_t;

  typedef enum logic [2:0] {
    e_coh_i,
    e_coh_s,
    e_coh_e,
    e_coh_m,
    e_coh_o,
    e_coh_f
  } coh_state_e;

  // encodings above wb are reserved
  typedef enum logic [3:0] {
    e_lce_cmd_sync,
    e_lce_cmd_inv,
    e_lce_cmd_st,
    e_lce_cmd_data,
    e_lce_cmd_wb
  } lce_cmd_type_e;

  typedef enum logic [2:0] {
    e_lce_resp_sync_ack,
    e_lce_resp_inv_ack,
    e_lce_resp_coh_ack,
    e_lce_resp_wb,
    e_lce_resp_null_wb
  } lce_resp_type_e;

  typedef enum logic [1:0] {
    e_tag_op_set_clear,
    e_tag_op_invalidate,
    e_tag_op_set_state,
    e_tag_op_set_tag
  } tag_op_e;

  typedef enum logic [1:0] {
    e_stat_op_set_clear,
    e_stat_op_read,
    e_stat_op_clear_dirty
  } stat_op_e;

  typedef enum logic {
    e_data_op_read,
    e_data_op_write
  } data_op_e;

  typedef struct packed {
    lce_cmd_type_e            msg_type;
    logic [id_width-1:0]      src_id;
    logic [paddr_width-1:0]   addr;
    logic [way_width-1:0]     way_id;
    coh_state_e               state;
  } lce_cmd_header_s;

  typedef struct packed {
    lce_cmd_header_s header;
    block_t          data;
  } lce_cmd_s;

  typedef struct packed {
    lce_resp_type_e           msg_type;
    logic [id_width-1:0]      src_id;
    logic [id_width-1:0]      dst_id;
    logic [paddr_width-1:0]   addr;
    logic [size_width-1:0]    size;
  } lce_resp_header_s;

  typedef struct packed {
    lce_resp_header_s header;
    block_t           data;
  } lce_resp_s;

  typedef struct packed {
    tag_op_e                  opcode;
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way_id;
    coh_state_e               state;
    logic [ptag_width-1:0]    tag;
  } tag_pkt_s;

  typedef struct packed {
    stat_op_e                 opcode;
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way_id;
  } stat_pkt_s;

  typedef struct packed {
    data_op_e                 opcode;
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way_id;
    block_t                   data;
  } data_pkt_s;

  // one dirty bit per way of the set that was read
  typedef struct packed {
    logic [assoc-1:0] dirty;
  } stat_info_s;

endpackage

// File: design/lce_cmd_top.sv
// Top level of the LCE command handler.
// Exposes the cache memory ports, the CCE command input and the response output
// as plain ports, and wires the controller to its two readback buffers.
// sets_p and num_cce_p are set here and passed down to the controller.

`timescale 1ns/1ps

module lce_cmd_top
  import lce_cmd_pkg::*;
#(
  parameter int unsigned sets_p    = 16,
  parameter int unsigned num_cce_p = 2
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [id_width-1:0] lce_id_i,

  output logic                ready_o,
  output logic                sync_done_o,

  output tag_pkt_s            tag_pkt_o,
  output logic                tag_pkt_v_o,
  input  logic                tag_pkt_yumi_i,

  output stat_pkt_s           stat_pkt_o,
  output logic                stat_pkt_v_o,
  input  logic                stat_pkt_yumi_i,
  input  stat_info_s          stat_mem_i,

  output data_pkt_s           data_pkt_o,
  output logic                data_pkt_v_o,
  input  logic                data_pkt_yumi_i,
  input  block_t              data_mem_i,

  output logic                cache_req_complete_o,

  input  lce_cmd_s            lce_cmd_i,
  input  logic                lce_cmd_v_i,
  output logic                lce_cmd_yumi_o,

  output lce_resp_s           lce_resp_o,
  output logic                lce_resp_v_o,
  input  logic                lce_resp_ready_i
);

  stat_info_s stat_buf;
  logic       stat_buf_v;
  block_t     data_buf;
  logic       data_buf_v;

  cache_mem_if #(.pkt_t(tag_pkt_s),  .rdata_t(logic))       tag_if  ();
  cache_mem_if #(.pkt_t(stat_pkt_s), .rdata_t(stat_info_s)) stat_if ();
  cache_mem_if #(.pkt_t(data_pkt_s), .rdata_t(block_t))     data_if ();

  // memory side of each port
  assign tag_pkt_o     = tag_if.pkt;
  assign tag_pkt_v_o   = tag_if.v;
  assign tag_if.yumi   = tag_pkt_yumi_i;
  assign tag_if.rdata  = 1'b0;

  assign stat_pkt_o    = stat_if.pkt;
  assign stat_pkt_v_o  = stat_if.v;
  assign stat_if.yumi  = stat_pkt_yumi_i;
  assign stat_if.rdata = stat_mem_i;

  assign data_pkt_o    = data_if.pkt;
  assign data_pkt_v_o  = data_if.v;
  assign data_if.yumi  = data_pkt_yumi_i;
  assign data_if.rdata = data_mem_i;

  lce_cmd_ctrl #(
    .sets_p    (sets_p),
    .num_cce_p (num_cce_p)
  ) ctrl (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lce_id_i             (lce_id_i),
    .tag_mem              (tag_if),
    .stat_mem             (stat_if),
    .data_mem             (data_if),
    .stat_buf_i           (stat_buf),
    .stat_buf_v_i         (stat_buf_v),
    .data_buf_i           (data_buf),
    .data_buf_v_i         (data_buf_v),
    .lce_cmd_i            (lce_cmd_i),
    .lce_cmd_v_i          (lce_cmd_v_i),
    .lce_cmd_yumi_o       (lce_cmd_yumi_o),
    .lce_resp_o           (lce_resp_o),
    .lce_resp_v_o         (lce_resp_v_o),
    .lce_resp_ready_i     (lce_resp_ready_i),
    .ready_o              (ready_o),
    .sync_done_o          (sync_done_o),
    .cache_req_complete_o (cache_req_complete_o)
  );

  lce_readback_buf #(
    .payload_t (stat_info_s),
    .read_op_p (e_stat_op_read)
  ) stat_rb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .mem     (stat_if),
    .data_o  (stat_buf),
    .v_o     (stat_buf_v)
  );

  lce_readback_buf #(
    .payload_t (block_t),
    .read_op_p (e_data_op_read)
  ) data_rb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .mem     (data_if),
    .data_o  (data_buf),
    .v_o     (data_buf_v)
  );

endmodule

// File: design/lce_readback_buf.sv
// Holds the result of the last read on a cache memory port.
// A read accepted in cycle t is loaded from rdata in cycle t+1 and reported valid
// from t+2 on, until the next read is accepted.

`timescale 1ns/1ps

module lce_readback_buf #(
  parameter type         payload_t = logic,
  parameter int unsigned read_op_p = 0
) (
  input  logic       clk_i,
  input  logic       reset_i,
  cache_mem_if.rdbuf mem,
  output payload_t   data_o,
  output logic       v_o
);

  logic     rd_accept;
  logic     rd_pend_r;
  payload_t data_r;

  assign rd_accept = mem.v & mem.yumi & (mem.pkt.opcode == read_op_p);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_pend_r <= 1'b0;
      v_o       <= 1'b0;
    end else begin
      rd_pend_r <= rd_accept;
      // a newly accepted read makes the held result stale
      if (rd_accept) begin
        v_o <= 1'b0;
      end else if (rd_pend_r) begin
        v_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_pend_r) begin
      data_r <= mem.rdata;
    end
  end

  assign data_o = data_r;

endmodule

// File: sources.f
+incdir+test
design/lce_cmd_pkg.sv
design/cache_mem_if.sv
design/lce_readback_buf.sv
design/lce_cmd_ctrl.sv
design/lce_cmd_top.sv
test/tb_lce_cmd.sv

// File: test/lce_cmd_tests.svh
// Directed tests and helpers for the LCE command handler testbench.
// Included inside tb_lce_cmd, so the tasks see its signals and memory model.

task automatic report_error(input string msg);
  error_cnt++;
  $display("[FAIL] %0t: %s", $time, msg);
endtask

function automatic logic [paddr_width-1:0] make_addr(input logic [ptag_width-1:0] tag,
                                                      input logic [index_width-1:0] index);
  return {tag, index, {block_offset_width{1'b0}}};
endfunction

function automatic lce_cmd_s make_cmd(input lce_cmd_type_e t, input logic [id_width-1:0] src,
                                      input logic [paddr_width-1:0] addr,
                                      input logic [way_width-1:0] way,
                                      input coh_state_e st, input block_t data);
  lce_cmd_s c;
  c.header.msg_type = t;
  c.header.src_id   = src;
  c.header.addr     = addr;
  c.header.way_id   = way;
  c.header.state    = st;
  c.data            = data;
  return c;
endfunction

// holds the command until the DUT dequeues it
task automatic send_cmd(input lce_cmd_s cmd);
  @(posedge clk_i);
  lce_cmd_i   <= cmd;
  lce_cmd_v_i <= 1'b1;
  @(negedge clk_i);
  while (lce_cmd_yumi_o !== 1'b1) begin
    @(negedge clk_i);
  end
  @(posedge clk_i);
  lce_cmd_v_i <= 1'b0;
endtask

task automatic take_resp(input lce_resp_type_e exp_type, input logic [paddr_width-1:0] exp_addr,
                         input logic [id_width-1:0] exp_dst, output lce_resp_s r);
  r = '0;
  if (resp_q.size() != 1) begin
    report_error($sformatf("expected one %s response, got %0d", exp_type.name(), resp_q.size()));
    resp_q.delete();
  end else begin
    r = resp_q.pop_front();
    if (r.header.msg_type != exp_type) begin
      report_error($sformatf("response type %0d, expected %s", r.header.msg_type, exp_type.name()));
    end
    if (r.header.src_id != lce_id_lp || r.header.dst_id != exp_dst) begin
      report_error($sformatf("response src %h dst %h", r.header.src_id, r.header.dst_id));
    end
    if (r.header.addr != exp_addr) begin
      report_error($sformatf("response addr %h, expected %h", r.header.addr, exp_addr));
    end
  end
endtask

// starts on the edge where reset is released
task automatic sweep_after_reset();
  for (int n = 0; n <= sets_lp + 1; n++) begin
    @(negedge clk_i);
    if (ready_o !== (n == sets_lp + 1)) begin
      report_error($sformatf("ready_o is %b %0d cycles after reset", ready_o, n));
    end
    if (n == 0 && {sync_done_o, lce_resp_v_o, lce_cmd_yumi_o, cache_req_complete_o,
                   tag_pkt_v_o, stat_pkt_v_o, data_pkt_v_o} !== 7'b0) begin
      report_error("outputs not low after reset");
    end
  end
  for (int i = 0; i < sets_lp; i++) begin
    if (clear_tag_cnt[i] != 1 || clear_stat_cnt[i] != 1) begin
      report_error($sformatf("set %0d cleared %0d/%0d times", i, clear_tag_cnt[i],
                             clear_stat_cnt[i]));
    end
  end
  if (other_pkt_cnt != 0) begin
    report_error($sformatf("%0d unexpected packets during the sweep", other_pkt_cnt));
  end
  tests_run++;
endtask

task automatic sync_handshake();
  lce_resp_s r;
  send_cmd(make_cmd(e_lce_cmd_sync, 4'h1, '0, '0, e_coh_i, '0));
  take_resp(e_lce_resp_sync_ack, '0, 4'h1, r);
  @(negedge clk_i);
  if (sync_done_o !== 1'b0) begin
    report_error("sync_done_o high after the first sync ack");
  end
  send_cmd(make_cmd(e_lce_cmd_sync, 4'h2, '0, '0, e_coh_i, '0));
  take_resp(e_lce_resp_sync_ack, '0, 4'h2, r);
  @(negedge clk_i);
  if (sync_done_o !== 1'b1) begin
    report_error("sync_done_o low after the last sync ack");
  end
  tests_run++;
endtask

task automatic invalidate_and_set_state();
  lce_resp_s               r;
  logic [ptag_width-1:0]   tag;
  logic [paddr_width-1:0]  addr;
  tag  = 24'ha5_5ac3;
  addr = make_addr(tag, 4'd5);
  ready_stall <= 1'b1;
  send_cmd(make_cmd(e_lce_cmd_st, 4'h1, addr, 2'd2, e_coh_e, '0));
  repeat (3) @(posedge clk_i);
  if (state_arr[5][2] != e_coh_e || tag_arr[5][2] != tag) begin
    report_error($sformatf("set state wrote %0d/%h", state_arr[5][2], tag_arr[5][2]));
  end
  if (resp_q.size() != 0) begin
    report_error("set state command produced a response");
    resp_q.delete();
  end
  send_cmd(make_cmd(e_lce_cmd_inv, 4'h1, addr, 2'd2, e_coh_i, '0));
  take_resp(e_lce_resp_inv_ack, addr, 4'h1, r);
  if (last_tag_pkt.opcode != e_tag_op_invalidate || last_tag_pkt.index != 4'd5 ||
      last_tag_pkt.way_id != 2'd2) begin
    report_error("invalidate packet has the wrong opcode, index or way");
  end
  if (state_arr[5][2] != e_coh_i) begin
    report_error("line still valid after invalidate");
  end
  ready_stall <= 1'b0;
  tests_run++;
endtask

task automatic data_fill();
  lce_resp_s              r;
  block_t                 blk;
  logic [ptag_width-1:0]  tag;
  logic [paddr_width-1:0] addr;
  int                     complete_before;
  blk  = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
  tag  = 24'h12_3456;
  addr = make_addr(tag, 4'd9);
  complete_before = complete_cnt;
  send_cmd(make_cmd(e_lce_cmd_data, 4'h2, addr, 2'd1, e_coh_m, blk));
  take_resp(e_lce_resp_coh_ack, addr, 4'h2, r);
  repeat (2) @(posedge clk_i);
  if (complete_cnt - complete_before != 1) begin
    report_error($sformatf("%0d request-complete pulses", complete_cnt - complete_before));
  end
  if (data_arr[9][1] != blk) begin
    report_error($sformatf("filled block %h", data_arr[9][1]));
  end
  if (tag_arr[9][1] != tag || state_arr[9][1] != e_coh_m) begin
    report_error($sformatf("filled tag %h state %0d", tag_arr[9][1], state_arr[9][1]));
  end
  tests_run++;
endtask

task automatic writeback_clean_dirty();
  lce_resp_s              r;
  block_t                 exp_blk;
  logic [paddr_width-1:0] addr;
  logic [size_width-1:0]  exp_size;
  exp_size = size_width'($clog2(block_width / 8));
  addr     = make_addr(24'h00_0777, 4'd3);
  send_cmd(make_cmd(e_lce_cmd_wb, 4'h1, addr, 2'd0, e_coh_i, '0));
  take_resp(e_lce_resp_null_wb, addr, 4'h1, r);
  // the filled line becomes dirty, as after a store hit
  @(posedge clk_i);
  dirty_arr[9][1] = 1'b1;
  exp_blk         = data_arr[9][1];
  addr            = make_addr(24'h12_3456, 4'd9);
  ready_stall <= 1'b1;
  send_cmd(make_cmd(e_lce_cmd_wb, 4'h2, addr, 2'd1, e_coh_i, '0));
  take_resp(e_lce_resp_wb, addr, 4'h2, r);
  if (r.data != exp_blk) begin
    report_error($sformatf("writeback block %h, expected %h", r.data, exp_blk));
  end
  if (r.header.size != exp_size) begin
    report_error($sformatf("writeback size %0d, expected %0d", r.header.size, exp_size));
  end
  if (dirty_arr[9][1] != 1'b0) begin
    report_error("dirty bit not cleared by writeback");
  end
  ready_stall <= 1'b0;
  tests_run++;
endtask

// File: test/tb_lce_cmd.sv
// Testbench for the LCE command handler.
// Drives CCE commands into lce_cmd_top, models the tag, stat and data memories
// with random yumi, and collects responses for the directed tests.
// The test tasks are included from lce_cmd_tests.svh.

`timescale 1ns/1ps

module tb_lce_cmd
  import lce_cmd_pkg::*;
();

  localparam int unsigned sets_lp    = 16;
  localparam int unsigned num_cce_lp = 2;
  localparam logic [id_width-1:0] lce_id_lp = 4'h5;
  // the tests take a few hundred cycles even with stalls
  localparam int unsigned timeout_cycles_lp = 5000;

  logic                clk_i;
  logic                reset_i;
  logic [id_width-1:0] lce_id_i;
  logic                ready_o;
  logic                sync_done_o;
  tag_pkt_s            tag_pkt_o;
  logic                tag_pkt_v_o;
  logic                tag_pkt_yumi_i;
  stat_pkt_s           stat_pkt_o;
  logic                stat_pkt_v_o;
  logic                stat_pkt_yumi_i;
  stat_info_s          stat_mem_i;
  data_pkt_s           data_pkt_o;
  logic                data_pkt_v_o;
  logic                data_pkt_yumi_i;
  block_t              data_mem_i;
  logic                cache_req_complete_o;
  lce_cmd_s            lce_cmd_i;
  logic                lce_cmd_v_i;
  logic                lce_cmd_yumi_o;
  lce_resp_s           lce_resp_o;
  logic                lce_resp_v_o;
  logic                lce_resp_ready_i;

  // cache memory model
  coh_state_e            state_arr [max_sets][assoc];
  logic [ptag_width-1:0] tag_arr   [max_sets][assoc];
  block_t                data_arr  [max_sets][assoc];
  logic [assoc-1:0]      dirty_arr [max_sets];
  int                    clear_tag_cnt  [max_sets];
  int                    clear_stat_cnt [max_sets];
  int                    other_pkt_cnt = 0;
  tag_pkt_s              last_tag_pkt;
  stat_info_s            stat_rd_next;
  block_t                data_rd_next;

  lce_resp_s resp_q [$];
  int        complete_cnt = 0;
  int        error_cnt    = 0;
  int        tests_run    = 0;
  int        cycle_cnt    = 0;
  integer    seed         = 32'h09a9_eb8e;
  logic      yumi_all_high;
  logic      ready_stall;

  lce_cmd_top #(
    .sets_p    (sets_lp),
    .num_cce_p (num_cce_lp)
  ) uut (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lce_id_i             (lce_id_i),
    .ready_o              (ready_o),
    .sync_done_o          (sync_done_o),
    .tag_pkt_o            (tag_pkt_o),
    .tag_pkt_v_o          (tag_pkt_v_o),
    .tag_pkt_yumi_i       (tag_pkt_yumi_i),
    .stat_pkt_o           (stat_pkt_o),
    .stat_pkt_v_o         (stat_pkt_v_o),
    .stat_pkt_yumi_i      (stat_pkt_yumi_i),
    .stat_mem_i           (stat_mem_i),
    .data_pkt_o           (data_pkt_o),
    .data_pkt_v_o         (data_pkt_v_o),
    .data_pkt_yumi_i      (data_pkt_yumi_i),
    .data_mem_i           (data_mem_i),
    .cache_req_complete_o (cache_req_complete_o),
    .lce_cmd_i            (lce_cmd_i),
    .lce_cmd_v_i          (lce_cmd_v_i),
    .lce_cmd_yumi_o       (lce_cmd_yumi_o),
    .lce_resp_o           (lce_resp_o),
    .lce_resp_v_o         (lce_resp_v_o),
    .lce_resp_ready_i     (lce_resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // yumi high about 3 of 4 cycles unless a test holds it high
  always @(posedge clk_i) begin
    tag_pkt_yumi_i   <= yumi_all_high || (($random(seed) & 3) != 0);
    stat_pkt_yumi_i  <= yumi_all_high || (($random(seed) & 3) != 0);
    data_pkt_yumi_i  <= yumi_all_high || (($random(seed) & 3) != 0);
    lce_resp_ready_i <= !ready_stall || (($random(seed) & 3) != 0);
  end

  // read data of the last accepted read, valid in the cycle after acceptance
  always @(posedge clk_i) begin
    stat_mem_i <= stat_rd_next;
    data_mem_i <= data_rd_next;
  end

  // accepted packets update the model and stage their read data
  always @(negedge clk_i) begin
    if (tag_pkt_v_o === 1'b1 && tag_pkt_yumi_i) begin
      last_tag_pkt = tag_pkt_o;
      case (tag_pkt_o.opcode)
        e_tag_op_set_clear: begin
          clear_tag_cnt[tag_pkt_o.index]++;
          for (int w = 0; w < assoc; w++) begin
            state_arr[tag_pkt_o.index][w] = e_coh_i;
          end
        end
        e_tag_op_invalidate: begin
          state_arr[tag_pkt_o.index][tag_pkt_o.way_id] = e_coh_i;
        end
        default: begin
          state_arr[tag_pkt_o.index][tag_pkt_o.way_id] = tag_pkt_o.state;
          tag_arr[tag_pkt_o.index][tag_pkt_o.way_id]   = tag_pkt_o.tag;
        end
      endcase
      if (tag_pkt_o.opcode != e_tag_op_set_clear) begin
        other_pkt_cnt++;
      end
    end
    if (stat_pkt_v_o === 1'b1 && stat_pkt_yumi_i) begin
      case (stat_pkt_o.opcode)
        e_stat_op_set_clear: begin
          clear_stat_cnt[stat_pkt_o.index]++;
          dirty_arr[stat_pkt_o.index] = '0;
        end
        e_stat_op_read: begin
          stat_rd_next.dirty = dirty_arr[stat_pkt_o.index];
        end
        default: begin
          dirty_arr[stat_pkt_o.index][stat_pkt_o.way_id] = 1'b0;
        end
      endcase
      if (stat_pkt_o.opcode != e_stat_op_set_clear) begin
        other_pkt_cnt++;
      end
    end
    if (data_pkt_v_o === 1'b1 && data_pkt_yumi_i) begin
      other_pkt_cnt++;
      if (data_pkt_o.opcode == e_data_op_write) begin
        data_arr[data_pkt_o.index][data_pkt_o.way_id] = data_pkt_o.data;
      end else begin
        data_rd_next = data_arr[data_pkt_o.index][data_pkt_o.way_id];
      end
    end
  end

  // response and completion monitor
  always @(negedge clk_i) begin
    if (lce_resp_v_o === 1'b1) begin
      resp_q.push_back(lce_resp_o);
      if (lce_resp_ready_i !== 1'b1) begin
        report_error("lce_resp_v_o high while lce_resp_ready_i is low");
      end
    end
    if (cache_req_complete_o === 1'b1) begin
      complete_cnt++;
      if (!(lce_cmd_yumi_o === 1'b1 && lce_resp_v_o === 1'b1 &&
            lce_resp_o.header.msg_type == e_lce_resp_coh_ack)) begin
        report_error("cache_req_complete_o not aligned with the coh_ack dequeue");
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles_lp) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
      $display("Test failures found");
      $finish;
    end
  end

  `include "lce_cmd_tests.svh"

  initial begin
    reset_i          = 1'b1;
    lce_id_i         = lce_id_lp;
    tag_pkt_yumi_i   = 1'b1;
    stat_pkt_yumi_i  = 1'b1;
    data_pkt_yumi_i  = 1'b1;
    stat_mem_i       = '0;
    data_mem_i       = '0;
    stat_rd_next     = '0;
    data_rd_next     = '0;
    lce_cmd_i        = '0;
    lce_cmd_v_i      = 1'b0;
    lce_resp_ready_i = 1'b1;
    yumi_all_high    = 1'b1;
    ready_stall      = 1'b0;
    // stale contents that the sweep or the tests must overwrite
    for (int i = 0; i < max_sets; i++) begin
      dirty_arr[i]      = '1;
      clear_tag_cnt[i]  = 0;
      clear_stat_cnt[i] = 0;
      for (int w = 0; w < assoc; w++) begin
        state_arr[i][w] = e_coh_m;
        tag_arr[i][w]   = {4{4'(i), 2'(w)}};
        data_arr[i][w]  = {16{4'(i), 4'(w)}};
      end
    end

    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    sweep_after_reset();
    yumi_all_high <= 1'b0;
    sync_handshake();
    invalidate_and_set_state();
    data_fill();
    writeback_clean_dirty();
    repeat (2) @(posedge clk_i);

    $display("tests run: %0d, errors: %0d", tests_run, error_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
